// File: dv/execute_ref_model.sv
package execute_ref_model;

    // What the stage must report for one accepted instruction.
    typedef struct packed {
        logic [31:0] result;
        logic        taken;
        logic        unsupported;
    } expect_t;

    // Predicts the stage outputs from the MIPS definition of each instruction.
    function automatic expect_t predict(input logic [31:0] instr, input logic [31:0] rs,
                                        input logic [31:0] rt);
        logic [5:0]  op;
        logic [4:0]  shamt;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic        branch;
        expect_t     e;
        op    = instr[31:26];
        shamt = instr[10:6];
        simm  = {{16{instr[15]}}, instr[15:0]}; // Adds, compares, addresses and branches.
        zimm  = {16'h0000, instr[15:0]};        // Logic immediates.
        e     = '0;
        case (op)
            mips_isa_pkg::OP_RTYPE: begin
                case (instr[5:0])
                    mips_isa_pkg::FN_SLL:  e.result = rt << shamt;
                    mips_isa_pkg::FN_SRL:  e.result = rt >> shamt;
                    mips_isa_pkg::FN_SRA:  e.result = $signed(rt) >>> shamt; // Sign fill.
                    mips_isa_pkg::FN_SLLV: e.result = rt << rs[4:0];
                    mips_isa_pkg::FN_SRLV: e.result = rt >> rs[4:0];
                    mips_isa_pkg::FN_SRAV: e.result = $signed(rt) >>> rs[4:0];
                    mips_isa_pkg::FN_ADDU: e.result = rs + rt;
                    mips_isa_pkg::FN_SUBU: e.result = rs - rt;
                    mips_isa_pkg::FN_AND:  e.result = rs & rt;
                    mips_isa_pkg::FN_OR:   e.result = rs | rt;
                    mips_isa_pkg::FN_XOR:  e.result = rs ^ rt;
                    mips_isa_pkg::FN_NOR:  e.result = ~(rs | rt);
                    mips_isa_pkg::FN_SLT:  e.result = {31'd0, $signed(rs) < $signed(rt)};
                    mips_isa_pkg::FN_SLTU: e.result = {31'd0, rs < rt};
                    default:               e.unsupported = 1'b1;
                endcase
            end
            // Address generation is base plus the sign-extended offset.
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH,
            mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
            mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW: e.result = rs + simm;
            mips_isa_pkg::OP_SLTI:  e.result = {31'd0, $signed(rs) < $signed(simm)};
            mips_isa_pkg::OP_SLTIU: e.result = {31'd0, rs < simm}; // Unsigned compare.
            mips_isa_pkg::OP_ANDI:  e.result = rs & zimm;
            mips_isa_pkg::OP_ORI:   e.result = rs | zimm;
            mips_isa_pkg::OP_XORI:  e.result = rs ^ zimm;
            mips_isa_pkg::OP_LUI:   e.result = {instr[15:0], 16'h0000};
            mips_isa_pkg::OP_BEQ:   e.taken = (rs == rt);
            mips_isa_pkg::OP_BNE:   e.taken = (rs != rt);
            mips_isa_pkg::OP_BLEZ:  e.taken = ($signed(rs) <= 0);
            mips_isa_pkg::OP_BGTZ:  e.taken = ($signed(rs) > 0);
            mips_isa_pkg::OP_REGIMM: begin
                case (instr[20:16])
                    mips_isa_pkg::RT_BLTZ: e.taken = ($signed(rs) < 0);
                    mips_isa_pkg::RT_BGEZ: e.taken = ($signed(rs) >= 0);
                    default:               e.unsupported = 1'b1; // Linking forms and others.
                endcase
            end
            default: e.unsupported = 1'b1;
        endcase
        branch = (op == mips_isa_pkg::OP_BEQ) || (op == mips_isa_pkg::OP_BNE) ||
                 (op == mips_isa_pkg::OP_BLEZ) || (op == mips_isa_pkg::OP_BGTZ) ||
                 (op == mips_isa_pkg::OP_REGIMM && !e.unsupported);
        // The stage reports the branch offset in bytes, the word offset in the immediate.
        if (branch) e.result = simm << 2;
        return e;
    endfunction

endpackage

// File: dv/execute_stage_tb.sv
module execute_stage_tb;

    localparam int NUM_TESTS  = 3000;
    localparam int CLK_PERIOD = 4;

    logic                clk;
    logic                reset;
    logic                in_valid;
    mips_isa_pkg::word_t instr;
    mips_isa_pkg::word_t rs_value;
    mips_isa_pkg::word_t rt_value;
    logic                result_valid;
    mips_isa_pkg::word_t result;
    logic                branch_taken;
    logic                unsupported;

    int                         errors = 0;
    logic                       accepted = 1'b0; // DUT saw in_valid high on the last edge.
    execute_ref_model::expect_t expected_q[$];   // Results still owed, oldest first.

    // Encoding pools per group, with R-type repeated so its functs get a fair share.
    mips_isa_pkg::opcode_t alu_ops[19] = '{
        mips_isa_pkg::OP_RTYPE, mips_isa_pkg::OP_RTYPE, mips_isa_pkg::OP_RTYPE,
        mips_isa_pkg::OP_RTYPE, mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LUI,
        mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LBU,
        mips_isa_pkg::OP_LHU, mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW,
        mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ANDI,
        mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI
    };
    mips_isa_pkg::funct_t alu_fns[8] = '{
        mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR,
        mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU
    };
    mips_isa_pkg::funct_t shift_fns[6] = '{
        mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA,
        mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV, mips_isa_pkg::FN_SRAV
    };
    mips_isa_pkg::opcode_t branch_ops[5] = '{
        mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE, mips_isa_pkg::OP_BLEZ,
        mips_isa_pkg::OP_BGTZ, mips_isa_pkg::OP_REGIMM
    };

    execute_stage u_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .instr        (instr),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .result_valid (result_valid),
        .result       (result),
        .branch_taken (branch_taken),
        .unsupported  (unsupported)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reports a mismatch between a DUT output and its expected value.
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // Boundary values come up often so that compares, shifts and branches hit their edges.
    function automatic mips_isa_pkg::word_t pick_operand();
        case ($urandom_range(0, 5))
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h7fff_ffff;
            3: return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // Drives one instruction of a random group with its operands.
    task automatic make_stimulus();
        execute_ref_model::expect_t probe;
        instr    = $urandom();
        rs_value = pick_operand();
        rt_value = ($urandom_range(0, 3) == 0) ? rs_value : pick_operand(); // Equal pairs.
        case ($urandom_range(0, 3))
            0: begin
                instr[31:26] = alu_ops[$urandom_range(0, 18)];
                instr[5:0]   = alu_fns[$urandom_range(0, 7)]; // Part of imm for I-types.
            end
            1: begin
                instr[31:26] = mips_isa_pkg::OP_RTYPE;
                instr[5:0]   = shift_fns[$urandom_range(0, 5)];
            end
            2: begin
                instr[31:26] = branch_ops[$urandom_range(0, 4)];
                instr[20:16] = $urandom_range(0, 1) ? mips_isa_pkg::RT_BLTZ
                                                    : mips_isa_pkg::RT_BGEZ;
            end
            default: begin
                do begin // Redraw until the encoding is outside the supported set.
                    instr = $urandom();
                    case ($urandom_range(0, 2))
                        0: instr[31:26] = mips_isa_pkg::OP_REGIMM;
                        1: instr[31:26] = mips_isa_pkg::OP_RTYPE;
                        default: ;
                    endcase
                    probe = execute_ref_model::predict(instr, rs_value, rt_value);
                end while (!probe.unsupported);
            end
        endcase
    endtask

    // Result of the previous cycle, which must appear exactly when an instruction was taken.
    task automatic check_outputs();
        execute_ref_model::expect_t exp;
        check_value("result_valid", accepted, result_valid);
        if (result_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("ERROR at time %0t: result_valid is high with no result owed", $time);
            end else begin
                exp = expected_q.pop_front();
                check_value("result", exp.result, result);
                check_value("branch_taken", exp.taken, branch_taken);
                check_value("unsupported", exp.unsupported, unsupported);
            end
        end
    endtask

    initial begin
        void'($urandom(88));
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        rs_value = '0;
        rt_value = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk); // One idle edge, and the outputs still show the reset state.
        check_value("result_valid", 1'b0, result_valid);
        check_value("result", 32'd0, result);
        check_value("branch_taken", 1'b0, branch_taken);
        check_value("unsupported", 1'b0, unsupported);
        for (int n = 0; n < NUM_TESTS; n++) begin
            @(negedge clk);
            check_outputs();
            make_stimulus();
            if (n < 2) begin // The pair 420 and 69 goes first, through addu and then subu.
                instr    = {mips_isa_pkg::OP_RTYPE, 20'd0,
                            (n == 0) ? mips_isa_pkg::FN_ADDU : mips_isa_pkg::FN_SUBU};
                rs_value = 32'd420;
                rt_value = 32'd69;
            end
            in_valid = (n < 2) || ($urandom_range(0, 2) != 0); // Idle on about a third.
            if (in_valid) begin
                expected_q.push_back(execute_ref_model::predict(instr, rs_value, rt_value));
            end
            accepted = in_valid;
        end
        @(negedge clk);
        check_outputs();
        in_valid = 1'b0;
        if (expected_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d results were never delivered", expected_q.size());
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog sized from the test length with a margin for reset and draining.
    initial begin
        #((NUM_TESTS + 20) * CLK_PERIOD);
        $display("ERROR: watchdog expired before the run finished");
        $display("sim failed");
        $finish;
    end

endmodule

// File: execute_stage.f
source/mips_isa_pkg.sv
source/exec_ctrl_pkg.sv
source/operand_select.sv
source/add_sub_logic.sv
source/shift_unit.sv
source/branch_resolve.sv
source/execute_stage.sv
dv/execute_ref_model.sv
dv/execute_stage_tb.sv

// File: source/add_sub_logic.sv
module add_sub_logic (
    input  mips_isa_pkg::opcode_t       opcode,
    input  mips_isa_pkg::funct_t        funct,
    input  mips_isa_pkg::word_t         op1,
    input  mips_isa_pkg::word_t         op2,
    output mips_isa_pkg::word_t         add_sub_out,
    output exec_ctrl_pkg::branch_cond_t branch_conditions,
    output logic                        alu_hit
);

    mips_isa_pkg::word_t sum;  // Result of the plain adder.
    logic [32:0]         diff; // Shared subtraction with the borrow on top.
    logic                lt_signed;
    logic                lt_unsigned;

    assign sum  = op1 + op2;
    assign diff = {1'b0, op1} - {1'b0, op2};

    // A borrow out of the zero-extended subtraction means op1 < op2 unsigned.
    assign lt_unsigned = diff[32];
    // With differing signs the negative operand is smaller and the difference can overflow.
    assign lt_signed = (op1[31] != op2[31]) ? op1[31] : diff[31];

    // Flags are computed for every instruction, and branch_resolve picks what it needs.
    assign branch_conditions[exec_ctrl_pkg::BC_EQ]   = (diff[31:0] == '0);
    assign branch_conditions[exec_ctrl_pkg::BC_NEG]  = op1[31];
    assign branch_conditions[exec_ctrl_pkg::BC_ZERO] = (op1 == '0);
    assign branch_conditions[exec_ctrl_pkg::BC_LT]   = lt_signed;

    always_comb begin
        add_sub_out = '0; // Unclaimed encodings give zero.
        alu_hit     = 1'b1;
        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                case (funct)
                    mips_isa_pkg::FN_ADDU: add_sub_out = sum;
                    mips_isa_pkg::FN_SUBU: add_sub_out = diff[31:0];
                    mips_isa_pkg::FN_AND:  add_sub_out = op1 & op2;
                    mips_isa_pkg::FN_OR:   add_sub_out = op1 | op2;
                    mips_isa_pkg::FN_XOR:  add_sub_out = op1 ^ op2;
                    mips_isa_pkg::FN_NOR:  add_sub_out = ~(op1 | op2);
                    mips_isa_pkg::FN_SLT:  add_sub_out = {31'd0, lt_signed};
                    mips_isa_pkg::FN_SLTU: add_sub_out = {31'd0, lt_unsigned};
                    default:               alu_hit = 1'b0; // Shifts and unknown functs.
                endcase
            end
            // lui arrives as 0 + (imm << 16), and loads and stores need base + offset.
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LUI,
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LW,
            mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
            mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW: begin
                add_sub_out = sum;
            end
            mips_isa_pkg::OP_SLTI:  add_sub_out = {31'd0, lt_signed};
            mips_isa_pkg::OP_SLTIU: add_sub_out = {31'd0, lt_unsigned}; // Sign-extended imm.
            mips_isa_pkg::OP_ANDI:  add_sub_out = op1 & op2;
            mips_isa_pkg::OP_ORI:   add_sub_out = op1 | op2;
            mips_isa_pkg::OP_XORI:  add_sub_out = op1 ^ op2;
            default: begin
                alu_hit = 1'b0; // Branches and everything this unit does not own.
            end
        endcase
    end

endmodule

// File: source/branch_resolve.sv
module branch_resolve (
    input  mips_isa_pkg::opcode_t       opcode,
    input  mips_isa_pkg::reg_idx_t      rt_field,
    input  exec_ctrl_pkg::branch_cond_t branch_conditions,
    output logic                        taken,
    output logic                        branch_hit
);

    logic eq;
    logic neg;
    logic zero;

    assign eq   = branch_conditions[exec_ctrl_pkg::BC_EQ];
    assign neg  = branch_conditions[exec_ctrl_pkg::BC_NEG];
    assign zero = branch_conditions[exec_ctrl_pkg::BC_ZERO];

    // Each branch reads one or two flags, and non-branches are never taken.
    always_comb begin
        taken      = 1'b0;
        branch_hit = 1'b1;
        case (opcode)
            mips_isa_pkg::OP_BEQ:  taken = eq;
            mips_isa_pkg::OP_BNE:  taken = !eq;
            mips_isa_pkg::OP_BLEZ: taken = neg | zero;    // rs <= 0.
            mips_isa_pkg::OP_BGTZ: taken = !(neg | zero); // rs > 0.
            mips_isa_pkg::OP_REGIMM: begin
                // Only two rt codes are branches here; the linking forms are not supported.
                case (rt_field)
                    mips_isa_pkg::RT_BLTZ: taken = neg;
                    mips_isa_pkg::RT_BGEZ: taken = !neg;
                    default:               branch_hit = 1'b0;
                endcase
            end
            default: branch_hit = 1'b0;
        endcase
    end

endmodule

// File: source/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

    // Flags that add_sub_logic derives from op1 and op2 for every instruction.
    typedef logic [3:0] branch_cond_t;

    // Bit positions inside branch_cond_t.
    localparam int BC_EQ   = 0; // Set when op1 equals op2.
    localparam int BC_NEG  = 1; // Set when op1 is negative.
    localparam int BC_ZERO = 2; // Set when op1 is zero.
    localparam int BC_LT   = 3; // Set when op1 is less than op2, both signed.

    // Names the unit whose output becomes the stage result.
    typedef logic [1:0] res_src_t;

    localparam res_src_t SRC_NONE   = 2'd0; // No unit claimed the instruction.
    localparam res_src_t SRC_ALU    = 2'd1; // Arithmetic, logic, compare or address.
    localparam res_src_t SRC_SHIFT  = 2'd2; // One of the six shifts.
    localparam res_src_t SRC_BRANCH = 2'd3; // A branch, so the result is its offset.

endpackage

// File: source/execute_stage.sv
module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  mips_isa_pkg::word_t instr,
    input  mips_isa_pkg::word_t rs_value,
    input  mips_isa_pkg::word_t rt_value,
    output logic                result_valid,
    output mips_isa_pkg::word_t result,
    output logic                branch_taken,
    output logic                unsupported
);

    mips_isa_pkg::opcode_t       opcode;
    mips_isa_pkg::funct_t        funct;
    mips_isa_pkg::reg_idx_t      rt_field;
    mips_isa_pkg::word_t         op1;
    mips_isa_pkg::word_t         op2;
    mips_isa_pkg::shamt_t        shift_amount;
    mips_isa_pkg::word_t         add_sub_out;
    exec_ctrl_pkg::branch_cond_t branch_conditions;
    logic                        alu_hit;
    mips_isa_pkg::word_t         shift_out;
    logic                        shift_hit;
    logic                        taken;
    logic                        branch_hit;
    exec_ctrl_pkg::res_src_t     res_src;     // Unit that claimed this instruction.
    mips_isa_pkg::word_t         result_next; // Merged result before the register.

    operand_select u_operand_select (
        .instr        (instr),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .opcode       (opcode),
        .funct        (funct),
        .rt_field     (rt_field),
        .op1          (op1),
        .op2          (op2),
        .shift_amount (shift_amount)
    );

    add_sub_logic u_add_sub_logic (
        .opcode            (opcode),
        .funct             (funct),
        .op1               (op1),
        .op2               (op2),
        .add_sub_out       (add_sub_out),
        .branch_conditions (branch_conditions),
        .alu_hit           (alu_hit)
    );

    shift_unit u_shift_unit (
        .opcode       (opcode),
        .funct        (funct),
        .op1          (op1),
        .shift_amount (shift_amount),
        .shift_out    (shift_out),
        .shift_hit    (shift_hit)
    );

    branch_resolve u_branch_resolve (
        .opcode            (opcode),
        .rt_field          (rt_field),
        .branch_conditions (branch_conditions),
        .taken             (taken),
        .branch_hit        (branch_hit)
    );

    // The units decode disjoint encodings, so at most one hit is high.
    always_comb begin
        if (alu_hit)         res_src = exec_ctrl_pkg::SRC_ALU;
        else if (shift_hit)  res_src = exec_ctrl_pkg::SRC_SHIFT;
        else if (branch_hit) res_src = exec_ctrl_pkg::SRC_BRANCH;
        else                 res_src = exec_ctrl_pkg::SRC_NONE;
    end

    always_comb begin
        case (res_src)
            exec_ctrl_pkg::SRC_ALU:    result_next = add_sub_out;
            exec_ctrl_pkg::SRC_SHIFT:  result_next = shift_out;
            // Branch offset in bytes, the sign-extended immediate times four.
            exec_ctrl_pkg::SRC_BRANCH: result_next = {{14{instr[15]}}, instr[15:0], 2'b00};
            default:                   result_next = '0;
        endcase
    end

    // One register stage, so the result appears the cycle after in_valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result       <= '0;
            branch_taken <= 1'b0;
            unsupported  <= 1'b0;
        end else begin
            result_valid <= in_valid;
            if (in_valid) begin // Data outputs hold while no instruction arrives.
                result       <= result_next;
                branch_taken <= taken;
                unsupported  <= (res_src == exec_ctrl_pkg::SRC_NONE);
            end
        end
    end

endmodule

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

    // Widths that carry a meaning in the instruction set.
    typedef logic [31:0] word_t;    // One data word, used for operands and results.
    typedef logic [5:0]  opcode_t;  // Major opcode in bits 31..26.
    typedef logic [5:0]  funct_t;   // R-type function in bits 5..0.
    typedef logic [4:0]  reg_idx_t; // Register index, as in the rs, rt and rd fields.
    typedef logic [4:0]  shamt_t;   // Shift amount in bits 10..6.
    typedef logic [15:0] imm_t;     // I-type immediate in bits 15..0.

    // Major opcodes of the supported integer instructions.
    localparam opcode_t OP_RTYPE  = 6'b000000;
    localparam opcode_t OP_REGIMM = 6'b000001; // The rt field picks bltz or bgez.
    localparam opcode_t OP_BEQ    = 6'b000100;
    localparam opcode_t OP_BNE    = 6'b000101;
    localparam opcode_t OP_BLEZ   = 6'b000110;
    localparam opcode_t OP_BGTZ   = 6'b000111;
    localparam opcode_t OP_ADDIU  = 6'b001001;
    localparam opcode_t OP_SLTI   = 6'b001010;
    localparam opcode_t OP_SLTIU  = 6'b001011;
    localparam opcode_t OP_ANDI   = 6'b001100;
    localparam opcode_t OP_ORI    = 6'b001101;
    localparam opcode_t OP_XORI   = 6'b001110;
    localparam opcode_t OP_LUI    = 6'b001111;
    // Loads and stores only need their address computed here.
    localparam opcode_t OP_LB     = 6'b100000;
    localparam opcode_t OP_LH     = 6'b100001;
    localparam opcode_t OP_LW     = 6'b100011;
    localparam opcode_t OP_LBU    = 6'b100100;
    localparam opcode_t OP_LHU    = 6'b100101;
    localparam opcode_t OP_SB     = 6'b101000;
    localparam opcode_t OP_SH     = 6'b101001;
    localparam opcode_t OP_SW     = 6'b101011;

    // Function codes under OP_RTYPE.
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    // The rt field values that select a branch under OP_REGIMM.
    localparam reg_idx_t RT_BLTZ = 5'b00000;
    localparam reg_idx_t RT_BGEZ = 5'b00001;

endpackage

// File: source/operand_select.sv
module operand_select (
    input  mips_isa_pkg::word_t    instr,
    input  mips_isa_pkg::word_t    rs_value,
    input  mips_isa_pkg::word_t    rt_value,
    output mips_isa_pkg::opcode_t  opcode,
    output mips_isa_pkg::funct_t   funct,
    output mips_isa_pkg::reg_idx_t rt_field,
    output mips_isa_pkg::word_t    op1,
    output mips_isa_pkg::word_t    op2,
    output mips_isa_pkg::shamt_t   shift_amount
);

    mips_isa_pkg::imm_t   imm;   // Raw 16-bit immediate.
    mips_isa_pkg::shamt_t shamt; // Shift amount held in the instruction.
    logic                 is_shift;
    logic                 is_var_shift;

    // Fixed field positions of the MIPS encoding.
    assign opcode   = instr[31:26];
    assign rt_field = instr[20:16];
    assign shamt    = instr[10:6];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];

    // Shifts take their data from rt, and the variable forms take the amount from rs.
    always_comb begin
        is_shift     = 1'b0;
        is_var_shift = 1'b0;
        if (opcode == mips_isa_pkg::OP_RTYPE) begin
            case (funct)
                mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA: begin
                    is_shift = 1'b1;
                end
                mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV, mips_isa_pkg::FN_SRAV: begin
                    is_shift     = 1'b1;
                    is_var_shift = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign shift_amount = is_var_shift ? rs_value[4:0] : shamt; // Only 5 bits of rs count.

    // lui becomes 0 + (imm << 16), so the adder produces it.
    assign op1 = (opcode == mips_isa_pkg::OP_LUI) ? '0 : (is_shift ? rt_value : rs_value);

    always_comb begin
        case (opcode)
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU,
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LW,
            mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
            mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW: begin
                op2 = {{16{imm[15]}}, imm}; // Sign extension for adds, compares and addresses.
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI: begin
                op2 = {16'h0000, imm}; // The logic immediates are zero-extended.
            end
            mips_isa_pkg::OP_LUI:   op2 = {imm, 16'h0000};
            default:                op2 = rt_value; // R-type and the branches compare rt.
        endcase
    end

endmodule

// File: source/shift_unit.sv
module shift_unit (
    input  mips_isa_pkg::opcode_t opcode,
    input  mips_isa_pkg::funct_t  funct,
    input  mips_isa_pkg::word_t   op1,
    input  mips_isa_pkg::shamt_t  shift_amount,
    output mips_isa_pkg::word_t   shift_out,
    output logic                  shift_hit
);

    logic shift_left;
    logic arithmetic;

    // Left shifts run through the right shifter on the bit-reversed word.
    function automatic mips_isa_pkg::word_t bit_reverse(input mips_isa_pkg::word_t value);
        mips_isa_pkg::word_t flipped;
        for (int i = 0; i < 32; i++) begin
            flipped[i] = value[31 - i];
        end
        return flipped;
    endfunction

    always_comb begin
        shift_left = 1'b0;
        arithmetic = 1'b0;
        shift_hit  = (opcode == mips_isa_pkg::OP_RTYPE);
        case (funct)
            mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SLLV: shift_left = 1'b1;
            mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRLV: ;               // Zero fill.
            mips_isa_pkg::FN_SRA, mips_isa_pkg::FN_SRAV: arithmetic = 1'b1; // Sign fill.
            default: shift_hit = 1'b0;
        endcase
    end

    always_comb begin
        mips_isa_pkg::word_t stage;
        logic                fill;
        fill  = arithmetic & op1[31];
        stage = shift_left ? bit_reverse(op1) : op1;
        // Five stages of 1, 2, 4, 8 and 16 bits.
        if (shift_amount[0]) stage = {fill, stage[31:1]};
        if (shift_amount[1]) stage = {{2{fill}}, stage[31:2]};
        if (shift_amount[2]) stage = {{4{fill}}, stage[31:4]};
        if (shift_amount[3]) stage = {{8{fill}}, stage[31:8]};
        if (shift_amount[4]) stage = {{16{fill}}, stage[31:16]};
        shift_out = shift_left ? bit_reverse(stage) : stage;
    end

endmodule
